/* include/dm_tile_settings.svh */
// Compute tile settings
// Address map of the core bus, mailbox register offsets and the
// sizes of the NoC flit and the mailbox queues

`ifndef DM_TILE_SETTINGS_SVH
`define DM_TILE_SETTINGS_SVH

// Flit width, equal to the bus data width
`define DM_TILE_FLIT_W 32

// Entries in each mailbox queue, power of two
`define DM_TILE_FIFO_DEPTH 4

// Address bit 31 at this value selects the DM port
`define DM_TILE_DM_REGION_MSB 1'b0

// Top address nibble of the NA mailbox
`define DM_TILE_NA_REGION 4'he

`define DM_TILE_REG_TX_DATA 4'h0  // Push flit, last cleared
`define DM_TILE_REG_TX_LAST 4'h4  // Push flit, last set
`define DM_TILE_REG_RX_DATA 4'h8  // Pop received flit
`define DM_TILE_REG_STATUS  4'hC  // Queue state

`endif

/* verilog/dm_tile_pkg.sv */
// Compute tile types
// Bus address views shared by the decoder and the mailbox, and the
// mailbox register index

package dm_tile_pkg;

   // Region view, used for slave selection
   typedef struct packed {
      logic [3:0]  region;
      logic [27:0] offset;
   } wb_region_t;

   // Register view, used inside the mailbox
   typedef struct packed {
      logic [27:0] upper;
      logic [1:0]  idx;
      logic [1:0]  byte_sel;
   } wb_reg_t;

   typedef union packed {
      wb_region_t region_v;
      wb_reg_t    reg_v;
   } wb_addr_u;

   typedef enum logic [1:0] {
      NA_REG_TX_DATA = 2'd0,
      NA_REG_TX_LAST = 2'd1,
      NA_REG_RX_DATA = 2'd2,
      NA_REG_STATUS  = 2'd3
   } na_reg_e;

endpackage

/* verilog/flit_fifo.sv */
// Flit queue
// First-word-fall-through circular buffer holding a flit and its last
// bit, with a fill count. Push and pop may share a cycle

`include "dm_tile_settings.svh"

module flit_fifo #(
   parameter int DEPTH = `DM_TILE_FIFO_DEPTH  // Power of two, 2 or more
) (
   input  logic                     clk,
   input  logic                     arst_n_i,
   input  logic                     push_i,
   input  logic [`DM_TILE_FLIT_W:0] push_data_i,  // {last, flit}
   input  logic                     pop_i,
   output logic [`DM_TILE_FLIT_W:0] pop_data_o,
   output logic                     empty_o,
   output logic                     full_o,
   output logic [$clog2(DEPTH):0]   count_o
);

   localparam int AW = $clog2(DEPTH);

   logic [`DM_TILE_FLIT_W:0] mem [DEPTH];
   logic [AW-1:0]            wr_ptr;
   logic [AW-1:0]            rd_ptr;
   logic                     do_push;
   logic                     do_pop;

   assign do_push    = push_i & ~full_o;
   assign do_pop     = pop_i & ~empty_o;
   assign empty_o    = count_o == '0;
   assign full_o     = count_o == (AW + 1)'(DEPTH);
   assign pop_data_o = mem[rd_ptr];  // Head always visible

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_o <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         if (do_push != do_pop) begin
            count_o <= do_push ? count_o + 1'b1 : count_o - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= push_data_i;
   end

endmodule

/* verilog/wb_addr_decode.sv */
// Wishbone classic address decoder
// Selects the DM port or the NA mailbox from the top address bits,
// returns the selected slave's response and answers unmapped
// addresses with a one-cycle error

`include "dm_tile_settings.svh"

module wb_addr_decode
   import dm_tile_pkg::*;
(
   input  logic                       clk,
   input  logic                       arst_n_i,
   // Core side
   input  logic [31:0]                wb_adr_i,
   input  logic [`DM_TILE_FLIT_W-1:0] wb_dat_i,
   input  logic [3:0]                 wb_sel_i,
   input  logic                       wb_we_i,
   input  logic                       wb_cyc_i,
   input  logic                       wb_stb_i,
   output logic [`DM_TILE_FLIT_W-1:0] wb_dat_o,
   output logic                       wb_ack_o,
   output logic                       wb_err_o,
   // DM side
   output logic [31:0]                dm_adr_o,
   output logic [`DM_TILE_FLIT_W-1:0] dm_dat_o,
   output logic [3:0]                 dm_sel_o,
   output logic                       dm_we_o,
   output logic                       dm_cyc_o,
   output logic                       dm_stb_o,
   input  logic [`DM_TILE_FLIT_W-1:0] dm_dat_i,
   input  logic                       dm_ack_i,
   input  logic                       dm_err_i,
   // Mailbox side
   output logic [31:0]                na_adr_o,
   output logic [`DM_TILE_FLIT_W-1:0] na_dat_o,
   output logic [3:0]                 na_sel_o,
   output logic                       na_we_o,
   output logic                       na_cyc_o,
   output logic                       na_stb_o,
   input  logic [`DM_TILE_FLIT_W-1:0] na_dat_i,
   input  logic                       na_ack_i,
   input  logic                       na_err_i
);

   wb_addr_u adr;
   logic     sel_dm;
   logic     sel_na;
   logic     sel_none;
   logic     err_q;    // Unmapped access responder

   assign adr      = wb_adr_i;
   assign sel_dm   = adr.region_v.region[3] == `DM_TILE_DM_REGION_MSB;
   assign sel_na   = adr.region_v.region == `DM_TILE_NA_REGION;
   assign sel_none = ~sel_dm & ~sel_na;

   // Request lines go to both, strobes to the selected slave only
   assign dm_adr_o = wb_adr_i;
   assign dm_dat_o = wb_dat_i;
   assign dm_sel_o = wb_sel_i;
   assign dm_we_o  = wb_we_i;
   assign dm_cyc_o = wb_cyc_i & sel_dm;
   assign dm_stb_o = wb_stb_i & sel_dm;

   assign na_adr_o = wb_adr_i;
   assign na_dat_o = wb_dat_i;
   assign na_sel_o = wb_sel_i;
   assign na_we_o  = wb_we_i;
   assign na_cyc_o = wb_cyc_i & sel_na;
   assign na_stb_o = wb_stb_i & sel_na;

   assign wb_dat_o = sel_dm ? dm_dat_i : (sel_na ? na_dat_i : '0);
   assign wb_ack_o = (sel_dm & dm_ack_i) | (sel_na & na_ack_i);
   assign wb_err_o = (sel_dm & dm_err_i) | (sel_na & na_err_i) | err_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= wb_cyc_i & wb_stb_i & sel_none & ~err_q;  // Single cycle pulse
      end
   end

endmodule

/* verilog/na_mailbox.sv */
// Network adapter mailbox
// Wishbone slave with a transmit queue feeding the NoC output channel
// and a receive queue filled from the NoC input channel. Raises the
// message interrupt while received flits wait

`include "dm_tile_settings.svh"

module na_mailbox
   import dm_tile_pkg::*;
(
   input  logic                       clk,
   input  logic                       arst_n_i,
   // Bus slave
   input  wb_addr_u                   na_adr_i,
   input  logic [`DM_TILE_FLIT_W-1:0] na_dat_i,
   input  logic [3:0]                 na_sel_i,
   input  logic                       na_we_i,
   input  logic                       na_cyc_i,
   input  logic                       na_stb_i,
   output logic [`DM_TILE_FLIT_W-1:0] na_dat_o,
   output logic                       na_ack_o,
   output logic                       na_err_o,
   // NoC
   input  logic [`DM_TILE_FLIT_W-1:0] noc_in_flit_i,
   input  logic                       noc_in_last_i,
   input  logic                       noc_in_valid_i,
   output logic                       noc_in_ready_o,
   output logic [`DM_TILE_FLIT_W-1:0] noc_out_flit_o,
   output logic                       noc_out_last_o,
   output logic                       noc_out_valid_o,
   input  logic                       noc_out_ready_i,
   output logic                       msg_irq_o
);

   localparam int W  = `DM_TILE_FLIT_W;
   localparam int CW = $clog2(`DM_TILE_FIFO_DEPTH) + 1;

   na_reg_e       reg_idx;
   logic          req;
   logic          acc_ok;
   logic          wr_tx;
   logic          rd_rx;
   logic          ack_q;
   logic          err_q;
   logic          push_q;     // Transmit push in the ack cycle
   logic          last_q;
   logic [W-1:0]  wdata_q;
   logic [W-1:0]  rdata_q;
   logic [W-1:0]  wdata_lanes;
   logic [W-1:0]  status;
   logic [W:0]    tx_head;
   logic [W:0]    rx_head;
   logic          tx_empty;
   logic          tx_full;
   logic          rx_empty;
   logic          rx_full;
   logic [CW-1:0] rx_count;

   assign reg_idx = na_reg_e'(na_adr_i.reg_v.idx);
   assign req     = na_cyc_i & na_stb_i & ~ack_q & ~err_q;  // New access
   assign wr_tx   = na_we_i & ((reg_idx == NA_REG_TX_DATA) | (reg_idx == NA_REG_TX_LAST));
   assign rd_rx   = ~na_we_i & (reg_idx == NA_REG_RX_DATA);
   assign acc_ok  = (wr_tx & ~tx_full) | (rd_rx & ~rx_empty)
                  | (~na_we_i & (reg_idx == NA_REG_STATUS));

   assign status = {{(W-8){1'b0}}, 4'(rx_count), 2'b00, tx_full, ~rx_empty};

   // Unselected byte lanes are written as zero
   always_comb begin
      for (int i = 0; i < W / 8; i++) begin
         wdata_lanes[8*i +: 8] = na_sel_i[i] ? na_dat_i[8*i +: 8] : 8'h00;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q  <= 1'b0;
         err_q  <= 1'b0;
         push_q <= 1'b0;
      end else begin
         ack_q  <= req & acc_ok;
         err_q  <= req & ~acc_ok;  // Refused access, no side effect
         push_q <= req & acc_ok & wr_tx;
      end
   end

   always_ff @(posedge clk) begin
      if (req) begin
         wdata_q <= wdata_lanes;
         last_q  <= reg_idx == NA_REG_TX_LAST;
         rdata_q <= rd_rx ? rx_head[W-1:0] : status;
      end
   end

   assign na_dat_o = rdata_q;
   assign na_ack_o = ack_q;
   assign na_err_o = err_q;

   flit_fifo #(.DEPTH(`DM_TILE_FIFO_DEPTH)) i_tx_fifo (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .push_i      (push_q),
      .push_data_i ({last_q, wdata_q}),
      .pop_i       (noc_out_valid_o & noc_out_ready_i),
      .pop_data_o  (tx_head),
      .empty_o     (tx_empty),
      .full_o      (tx_full),
      .count_o     ()
   );

   flit_fifo #(.DEPTH(`DM_TILE_FIFO_DEPTH)) i_rx_fifo (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .push_i      (noc_in_valid_i & noc_in_ready_o),
      .push_data_i ({noc_in_last_i, noc_in_flit_i}),
      .pop_i       (req & acc_ok & rd_rx),
      .pop_data_o  (rx_head),
      .empty_o     (rx_empty),
      .full_o      (rx_full),
      .count_o     (rx_count)
   );

   assign noc_out_flit_o  = tx_head[W-1:0];
   assign noc_out_last_o  = tx_head[W];
   assign noc_out_valid_o = ~tx_empty;
   assign noc_in_ready_o  = ~rx_full;
   assign msg_irq_o       = ~rx_empty;  // Message waiting

endmodule

/* verilog/dm_tile_top.sv */
// Distributed-memory compute tile, bus side
// The core's Wishbone port is split by address onto the external data
// memory port and the network adapter mailbox

module dm_tile_top
   import dm_tile_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n_i,
   // Core bus
   input  logic [31:0] wb_adr_i,
   input  logic [31:0] wb_dat_i,
   input  logic [3:0]  wb_sel_i,
   input  logic        wb_we_i,
   input  logic        wb_cyc_i,
   input  logic        wb_stb_i,
   output logic [31:0] wb_dat_o,
   output logic        wb_ack_o,
   output logic        wb_err_o,
   // External data memory
   output logic [31:0] dm_adr_o,
   output logic [31:0] dm_dat_o,
   output logic [3:0]  dm_sel_o,
   output logic        dm_we_o,
   output logic        dm_cyc_o,
   output logic        dm_stb_o,
   input  logic [31:0] dm_dat_i,
   input  logic        dm_ack_i,
   input  logic        dm_err_i,
   // NoC channel
   input  logic [31:0] noc_in_flit_i,
   input  logic        noc_in_last_i,
   input  logic        noc_in_valid_i,
   output logic        noc_in_ready_o,
   output logic [31:0] noc_out_flit_o,
   output logic        noc_out_last_o,
   output logic        noc_out_valid_o,
   input  logic        noc_out_ready_i,
   output logic        msg_irq_o
);

   wb_addr_u    na_adr;   // Mailbox side bus
   logic [31:0] na_wdat;
   logic [31:0] na_rdat;
   logic [3:0]  na_sel;
   logic        na_we;
   logic        na_cyc;
   logic        na_stb;
   logic        na_ack;
   logic        na_err;

   wb_addr_decode i_wb_addr_decode (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_sel_i (wb_sel_i),
      .wb_we_i  (wb_we_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .wb_err_o (wb_err_o),
      .dm_adr_o (dm_adr_o),
      .dm_dat_o (dm_dat_o),
      .dm_sel_o (dm_sel_o),
      .dm_we_o  (dm_we_o),
      .dm_cyc_o (dm_cyc_o),
      .dm_stb_o (dm_stb_o),
      .dm_dat_i (dm_dat_i),
      .dm_ack_i (dm_ack_i),
      .dm_err_i (dm_err_i),
      .na_adr_o (na_adr),
      .na_dat_o (na_wdat),
      .na_sel_o (na_sel),
      .na_we_o  (na_we),
      .na_cyc_o (na_cyc),
      .na_stb_o (na_stb),
      .na_dat_i (na_rdat),
      .na_ack_i (na_ack),
      .na_err_i (na_err)
   );

   na_mailbox i_na_mailbox (
      .clk             (clk),
      .arst_n_i        (arst_n_i),
      .na_adr_i        (na_adr),
      .na_dat_i        (na_wdat),
      .na_sel_i        (na_sel),
      .na_we_i         (na_we),
      .na_cyc_i        (na_cyc),
      .na_stb_i        (na_stb),
      .na_dat_o        (na_rdat),
      .na_ack_o        (na_ack),
      .na_err_o        (na_err),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_last_i   (noc_in_last_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_last_o  (noc_out_last_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .msg_irq_o       (msg_irq_o)
   );

endmodule

/* dv/dm_mem_model.sv */
// Behavioral external data memory
// Wishbone classic slave behind the DM port, 64 words deep with
// byte-lane writes. Answers one cycle after stb and counts accesses

module dm_mem_model (
   input  logic        clk,
   input  logic        arst_n_i,
   input  logic [31:0] adr_i,
   input  logic [31:0] dat_i,
   input  logic [3:0]  sel_i,
   input  logic        we_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   output logic [31:0] dat_o,
   output logic        ack_o,
   output logic        err_o,
   output int          access_cnt_o
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [31:0] mem [64];
   logic [5:0]  idx;
   logic        req;

   assign idx   = adr_i[7:2];  // Word index, upper bits alias
   assign req   = cyc_i & stb_i & ~ack_o;
   assign err_o = 1'b0;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_o        <= 1'b0;
         dat_o        <= '0;
         access_cnt_o <= 0;
      end else begin
         ack_o <= req;
         if (req) begin
            dat_o        <= mem[idx];
            access_cnt_o <= access_cnt_o + 1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req && we_i) begin
         for (int i = 0; i < 4; i++) begin
            if (sel_i[i]) mem[idx][8*i +: 8] <= dat_i[8*i +: 8];
         end
      end
   end

endmodule

/* dv/dm_tile_tb.sv */
// Compute tile testbench
// Directed tests of the DM port, unmapped addresses and the NA mailbox
// transmit, receive and full-queue behavior

`include "dm_tile_settings.svh"

module dm_tile_tb
   import dm_tile_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 8;
   localparam int NUM_TESTS  = 5;

   logic        clk;
   logic        arst_n_i;
   logic [31:0] wb_adr_i;
   logic [31:0] wb_dat_i;
   logic [31:0] wb_dat_o;
   logic [3:0]  wb_sel_i;
   logic        wb_we_i;
   logic        wb_cyc_i;
   logic        wb_stb_i;
   logic        wb_ack_o;
   logic        wb_err_o;
   logic [31:0] dm_adr_o;
   logic [31:0] dm_dat_o;
   logic [31:0] dm_dat_i;
   logic [3:0]  dm_sel_o;
   logic        dm_we_o;
   logic        dm_cyc_o;
   logic        dm_stb_o;
   logic        dm_ack_i;
   logic        dm_err_i;
   logic [31:0] noc_in_flit_i;
   logic [31:0] noc_out_flit_o;
   logic        noc_in_last_i;
   logic        noc_in_valid_i;
   logic        noc_in_ready_o;
   logic        noc_out_last_o;
   logic        noc_out_valid_o;
   logic        noc_out_ready_i;
   logic        msg_irq_o;
   int          dm_access_cnt;
   logic [31:0] lfsr_state = 32'h15f1_0fc9;
   int          ready_mode = 0;  // 0 low, 1 high, 2 from LFSR
   logic [32:0] tx_seen [$];     // {last, flit} leaving noc_out

   dm_tile_top i_dm_tile_top (.*);

   dm_mem_model i_dm_mem_model (
      .clk (clk), .arst_n_i (arst_n_i),
      .adr_i (dm_adr_o), .dat_i (dm_dat_o), .sel_i (dm_sel_o), .we_i (dm_we_o),
      .cyc_i (dm_cyc_o), .stb_i (dm_stb_o), .dat_o (dm_dat_i), .ack_o (dm_ack_i),
      .err_o (dm_err_i), .access_cnt_o (dm_access_cnt)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(NUM_TESTS * 400 * CLK_PERIOD);
      $display("Watchdog timeout, the DUT stopped responding");
      $display("CHECKS FAILED");
      $fatal(1);
   end

   initial begin
      noc_out_ready_i = 1'b0;
      forever begin
         @(posedge clk);
         noc_out_ready_i <= (ready_mode == 2) ? lfsr_bit() : (ready_mode == 1);
      end
   end

   initial begin
      forever begin
         @(negedge clk);
         if (noc_out_valid_o && noc_out_ready_i) begin
            tx_seen.push_back({noc_out_last_o, noc_out_flit_o});  // Moves at next edge
         end
      end
   end

   // Galois LFSR for x^32 + x^22 + x^2 + x + 1
   function automatic logic lfsr_bit();
      logic out;
      out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out) lfsr_state = lfsr_state ^ 32'h8020_0003;
      return out;
   endfunction

   function automatic logic [31:0] lfsr_word();
      logic [31:0] w;
      w = '0;
      for (int i = 0; i < 32; i++) begin
         w = {w[30:0], lfsr_bit()};
      end
      return w;
   endfunction

   function automatic logic [31:0] reg_addr(input na_reg_e r);
      logic [3:0] off;
      case (r)
         NA_REG_TX_DATA: off = `DM_TILE_REG_TX_DATA;
         NA_REG_TX_LAST: off = `DM_TILE_REG_TX_LAST;
         NA_REG_RX_DATA: off = `DM_TILE_REG_RX_DATA;
         default:        off = `DM_TILE_REG_STATUS;
      endcase
      return {`DM_TILE_NA_REGION, 24'h00_0000, off};
   endfunction

   function automatic logic [31:0] merge_lanes(input logic [31:0] old_w, input logic [31:0] new_w,
                                               input logic [3:0] sel);
      logic [31:0] res;
      res = old_w;
      for (int i = 0; i < 4; i++) begin
         if (sel[i]) res[8*i +: 8] = new_w[8*i +: 8];
      end
      return res;
   endfunction

   // STATUS holds the rx count in 7:4, tx full in 1 and rx not empty in 0
   function automatic logic [31:0] status_word(input logic [3:0] rx_cnt, input logic tx_full,
                                               input logic rx_nonempty);
      return {24'h00_0000, rx_cnt, 2'b00, tx_full, rx_nonempty};
   endfunction

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("CHECK FAILED: %s = 0x%08h, expected 0x%08h", name, got, exp);
         $display("CHECKS FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         $display("CHECK FAILED: %s = 0x%0h, expected 0x%0h", name, got, exp);
         $display("CHECKS FAILED");
         $fatal(1);
      end
   endtask

   // One classic cycle that ends on ack or err
   task automatic bus_access(input logic [31:0] addr, input logic we, input logic [31:0] wdata,
                             input logic [3:0] sel, input logic exp_ok,
                             output logic [31:0] rdata);
      @(posedge clk);
      wb_adr_i <= addr;
      wb_dat_i <= wdata;
      wb_sel_i <= sel;
      wb_we_i  <= we;
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      do begin
         @(negedge clk);
      end while (!(wb_ack_o || wb_err_o));
      check_bit("wb_ack_o", wb_ack_o, exp_ok);
      check_bit("wb_err_o", wb_err_o, ~exp_ok);
      rdata = wb_dat_o;
      @(posedge clk);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] sel, input logic exp_ok);
      logic [31:0] unused_rd;
      bus_access(addr, 1'b1, data, sel, exp_ok, unused_rd);
   endtask

   task automatic bus_read(input logic [31:0] addr, input logic exp_ok, output logic [31:0] data);
      bus_access(addr, 1'b0, 32'h0, 4'hf, exp_ok, data);
   endtask

   task automatic send_flit(input logic [31:0] flit, input logic last);
      @(posedge clk);
      noc_in_flit_i  <= flit;
      noc_in_last_i  <= last;
      noc_in_valid_i <= 1'b1;
      do begin
         @(negedge clk);
      end while (!noc_in_ready_o);
      @(posedge clk);              // Accepted on this edge
      noc_in_valid_i <= 1'b0;
   endtask

   task automatic check_reset_values();
      check_bit("wb_ack_o", wb_ack_o, 1'b0);
      check_bit("wb_err_o", wb_err_o, 1'b0);
      check_bit("noc_out_valid_o", noc_out_valid_o, 1'b0);
      check_bit("msg_irq_o", msg_irq_o, 1'b0);
      check_bit("noc_in_ready_o", noc_in_ready_o, 1'b1);
   endtask

   task automatic test_dm_round_trip();
      logic [31:0] addrs [4];
      logic [31:0] mirror [4];
      logic [31:0] data;
      addrs = '{32'h0000_0000, 32'h0000_0010, 32'h1000_0020, 32'h7fff_fffc};
      for (int i = 0; i < 4; i++) begin
         mirror[i] = lfsr_word();
         bus_write(addrs[i], mirror[i], 4'hf, 1'b1);
      end
      data = lfsr_word();
      bus_write(addrs[1], data, 4'b0101, 1'b1);
      mirror[1] = merge_lanes(mirror[1], data, 4'b0101);
      data = lfsr_word();
      bus_write(addrs[3], data, 4'b1000, 1'b1);
      mirror[3] = merge_lanes(mirror[3], data, 4'b1000);
      for (int i = 0; i < 4; i++) begin
         bus_read(addrs[i], 1'b1, data);
         check_word("wb_dat_o", data, mirror[i]);
      end
   endtask

   task automatic test_unmapped();
      int          cnt_before;
      logic [31:0] data;
      cnt_before = dm_access_cnt;
      bus_write(32'h9000_0000, lfsr_word(), 4'hf, 1'b0);
      bus_read(32'hf000_0000, 1'b0, data);
      check_word("dm_access_cnt", dm_access_cnt, cnt_before);
   endtask

   task automatic test_tx_backpressure();
      logic [31:0] words [4];
      for (int i = 0; i < 4; i++) begin
         words[i] = lfsr_word();
      end
      tx_seen.delete();
      @(negedge clk);
      ready_mode = 2;
      for (int i = 0; i < 4; i++) begin
         bus_write(reg_addr(i == 3 ? NA_REG_TX_LAST : NA_REG_TX_DATA), words[i], 4'hf, 1'b1);
      end
      while (tx_seen.size() < 4) @(negedge clk);
      ready_mode = 0;
      for (int i = 0; i < 4; i++) begin
         check_word("noc_out_flit_o", tx_seen[i][31:0], words[i]);
         check_bit("noc_out_last_o", tx_seen[i][32], i == 3);
      end
   endtask

   task automatic test_rx_irq();
      logic [31:0] flits [3];
      logic [31:0] data;
      for (int i = 0; i < 3; i++) begin
         flits[i] = lfsr_word();
      end
      check_bit("msg_irq_o", msg_irq_o, 1'b0);
      for (int i = 0; i < 3; i++) begin
         send_flit(flits[i], i == 2);
      end
      @(negedge clk);
      check_bit("msg_irq_o", msg_irq_o, 1'b1);
      bus_read(reg_addr(NA_REG_STATUS), 1'b1, data);
      check_word("wb_dat_o", data, status_word(4'd3, 1'b0, 1'b1));
      for (int i = 0; i < 3; i++) begin
         check_bit("msg_irq_o", msg_irq_o, 1'b1);
         bus_read(reg_addr(NA_REG_RX_DATA), 1'b1, data);
         check_word("wb_dat_o", data, flits[i]);
      end
      @(negedge clk);
      check_bit("msg_irq_o", msg_irq_o, 1'b0);
      bus_read(reg_addr(NA_REG_RX_DATA), 1'b0, data);  // Empty queue
   endtask

   task automatic test_full_queues();
      logic [31:0] words [`DM_TILE_FIFO_DEPTH];
      logic [31:0] data;
      @(negedge clk);
      ready_mode = 0;
      @(negedge clk);
      for (int i = 0; i < `DM_TILE_FIFO_DEPTH; i++) begin
         words[i] = lfsr_word();
         bus_write(reg_addr(NA_REG_TX_DATA), words[i], 4'hf, 1'b1);
      end
      bus_read(reg_addr(NA_REG_STATUS), 1'b1, data);
      check_word("wb_dat_o", data, status_word(4'd0, 1'b1, 1'b0));
      bus_write(reg_addr(NA_REG_TX_DATA), lfsr_word(), 4'hf, 1'b0);
      bus_read(reg_addr(NA_REG_TX_DATA), 1'b0, data);
      tx_seen.delete();
      @(negedge clk);
      ready_mode = 1;
      while (tx_seen.size() < `DM_TILE_FIFO_DEPTH) @(negedge clk);
      repeat (4) @(negedge clk);  // Nothing more may leave
      check_word("drained flit count", tx_seen.size(), `DM_TILE_FIFO_DEPTH);
      check_bit("noc_out_valid_o", noc_out_valid_o, 1'b0);
      for (int i = 0; i < `DM_TILE_FIFO_DEPTH; i++) begin
         check_word("noc_out_flit_o", tx_seen[i][31:0], words[i]);
      end
   endtask

   initial begin
      arst_n_i       = 1'b0;
      wb_adr_i       = '0;
      wb_dat_i       = '0;
      wb_sel_i       = '0;
      wb_we_i        = 1'b0;
      wb_cyc_i       = 1'b0;
      wb_stb_i       = 1'b0;
      noc_in_flit_i  = '0;
      noc_in_last_i  = 1'b0;
      noc_in_valid_i = 1'b0;
      repeat (10) @(posedge clk);
      arst_n_i <= 1'b1;
      @(negedge clk);
      check_reset_values();
      test_dm_round_trip();
      test_unmapped();
      test_tx_backpressure();
      test_rx_irq();
      test_full_queues();
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* dm_tile.f */
+incdir+include
verilog/dm_tile_pkg.sv
verilog/flit_fifo.sv
verilog/wb_addr_decode.sv
verilog/na_mailbox.sv
verilog/dm_tile_top.sv
dv/dm_mem_model.sv
dv/dm_tile_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the compute tile testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f dm_tile.f --top-module dm_tile_tb -o dm_tile_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/dm_tile_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
fi
echo "Pass message not found"
exit 1
